// ==== verilog/exec_pkg.sv ====
package exec_pkg;

  typedef enum logic [4:0] {
    op_nop,
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_sll,
    op_srl,
    op_sra,
    op_slt,
    op_sltu,
    op_lui,
    op_beq,
    op_bne,
    op_blt,
    op_bge,
    op_jal,
    op_div,
    op_divu,
    op_rem,
    op_remu,
    op_illegal
  } exec_op_t;

  typedef enum logic [3:0] {
    cause_none = 4'd0,
    cause_illegal_instruction = 4'd2,
    cause_breakpoint = 4'd3
  } ecause_t;

  typedef struct packed {
    logic valid;
    exec_op_t op;
    logic use_imm;
    logic [4:0] waddr;
    logic ebreak;
  } lane_ctrl_t;

  function automatic logic is_divide(input exec_op_t op);
    return op inside {op_div, op_divu, op_rem, op_remu};
  endfunction

endpackage

// ==== verilog/exec_lane_if.sv ====
`timescale 1ns/1ps

interface exec_lane_if #(
  parameter int data_width = 32
);
  import exec_pkg::*;

  lane_ctrl_t ctrl;
  logic [data_width-1:0] pc;
  logic [data_width-1:0] rdata1;
  logic [data_width-1:0] rdata2;
  logic [data_width-1:0] imm;
  logic [data_width-1:0] result;
  logic jump;
  logic [data_width-1:0] target;
  ecause_t ecause;

  modport src (output ctrl, pc, rdata1, rdata2, imm, result, jump, target, ecause);
  modport dst (input ctrl, pc, rdata1, rdata2, imm, result, jump, target, ecause);

endinterface

// ==== verilog/int_alu.sv ====
`timescale 1ns/1ps

module int_alu #(
  parameter int data_width = 32
) (
  input exec_pkg::exec_op_t op,
  input logic use_imm,
  input logic [data_width-1:0] pc,
  input logic [data_width-1:0] rdata1,
  input logic [data_width-1:0] rdata2,
  input logic [data_width-1:0] imm,
  output logic [data_width-1:0] result,
  output logic jump,
  output logic [data_width-1:0] target
);
  import exec_pkg::*;

  localparam int shift_bits = $clog2(data_width);

  logic [data_width-1:0] opb;
  logic [shift_bits-1:0] shamt;

  assign opb = use_imm ? imm : rdata2;
  assign shamt = opb[shift_bits-1:0];
  assign target = pc + imm;

  always_comb begin
    result = '0;
    jump = 1'b0;
    case (op)
      op_add: result = rdata1 + opb;
      op_sub: result = rdata1 - opb;
      op_and: result = rdata1 & opb;
      op_or: result = rdata1 | opb;
      op_xor: result = rdata1 ^ opb;
      op_sll: result = rdata1 << shamt;
      op_srl: result = rdata1 >> shamt;
      op_sra: result = $signed(rdata1) >>> shamt;
      op_slt: result = data_width'($signed(rdata1) < $signed(opb));
      op_sltu: result = data_width'(rdata1 < opb);
      op_lui: result = imm;
      op_beq: jump = rdata1 == rdata2; // compares use rs2 only.
      op_bne: jump = rdata1 != rdata2;
      op_blt: jump = $signed(rdata1) < $signed(rdata2);
      op_bge: jump = $signed(rdata1) >= $signed(rdata2);
      op_jal: begin
        jump = 1'b1;
        result = pc + data_width'(4); // link value.
      end
      default: result = '0;
    endcase
  end

endmodule

// ==== verilog/serial_divider.sv ====
`timescale 1ns/1ps

module serial_divider #(
  parameter int data_width = 32
) (
  input logic clock,
  input logic reset,
  input logic flush,
  input logic start,
  input logic signed_op,
  input logic want_rem,
  input logic [data_width-1:0] dividend,
  input logic [data_width-1:0] divisor,
  output logic busy,
  output logic done,
  output logic [data_width-1:0] result
);

  logic [$clog2(data_width):0] count;
  logic [data_width-1:0] rem_q;
  logic [data_width-1:0] quo_q;
  logic [data_width-1:0] div_q;
  logic neg_q;
  logic neg_r;
  logic rem_sel;
  logic a_neg;
  logic b_neg;
  logic [data_width:0] trial;
  logic [data_width:0] diff;
  logic [data_width-1:0] rem_next;
  logic [data_width-1:0] quo_next;

  assign a_neg = signed_op & dividend[data_width-1];
  assign b_neg = signed_op & divisor[data_width-1];

  // one restoring step per cycle.
  always_comb begin
    trial = {rem_q, quo_q[data_width-1]};
    diff = trial - {1'b0, div_q};
    quo_next = {quo_q[data_width-2:0], ~diff[data_width]};
    rem_next = diff[data_width] ? trial[data_width-1:0] : diff[data_width-1:0];
  end

  always_ff @(posedge clock) begin
    if (!reset || flush) begin
      busy <= 1'b0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start && !busy) begin
        busy <= 1'b1;
      end else if (busy && count == 1) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (start && !busy) begin
      count <= ($clog2(data_width)+1)'(data_width);
      rem_q <= '0;
      quo_q <= a_neg ? -dividend : dividend;
      div_q <= b_neg ? -divisor : divisor;
      neg_q <= (a_neg ^ b_neg) && divisor != '0; // x/0 stays all ones.
      neg_r <= a_neg;
      rem_sel <= want_rem;
    end else if (busy) begin
      count <= count - 1'b1;
      rem_q <= rem_next;
      quo_q <= quo_next;
      if (count == 1) begin
        if (rem_sel) begin
          result <= neg_r ? -rem_next : rem_next;
        end else begin
          result <= neg_q ? -quo_next : quo_next;
        end
      end
    end
  end

endmodule

// ==== verilog/issue_buffer.sv ====
`timescale 1ns/1ps

module issue_buffer #(
  parameter int data_width = 32
) (
  input logic clock,
  input logic reset,
  input logic flush,
  input logic issue_valid,
  output logic issue_ready,
  input exec_pkg::exec_op_t lane_0_op,
  input logic lane_0_use_imm,
  input logic [4:0] lane_0_waddr,
  input logic lane_0_ebreak,
  input logic [data_width-1:0] lane_0_pc,
  input logic [data_width-1:0] lane_0_rdata1,
  input logic [data_width-1:0] lane_0_rdata2,
  input logic [data_width-1:0] lane_0_imm,
  input exec_pkg::exec_op_t lane_1_op,
  input logic lane_1_use_imm,
  input logic [4:0] lane_1_waddr,
  input logic lane_1_ebreak,
  input logic [data_width-1:0] lane_1_pc,
  input logic [data_width-1:0] lane_1_rdata1,
  input logic [data_width-1:0] lane_1_rdata2,
  input logic [data_width-1:0] lane_1_imm,
  input logic stage_stall,
  exec_lane_if.src pair0,
  exec_lane_if.src pair1,
  output logic pair_valid
);
  import exec_pkg::*;

  localparam int pay_width = 4 * data_width;

  lane_ctrl_t in_ctrl [2];
  lane_ctrl_t held_ctrl [2];
  logic [pay_width-1:0] in_pay [2];
  logic [pay_width-1:0] held_pay [2];
  logic full;

  assign in_ctrl[0] = '{lane_0_op != op_nop, lane_0_op, lane_0_use_imm, lane_0_waddr,
                        lane_0_ebreak};
  assign in_ctrl[1] = '{lane_1_op != op_nop, lane_1_op, lane_1_use_imm, lane_1_waddr,
                        lane_1_ebreak};
  assign in_pay[0] = {lane_0_pc, lane_0_rdata1, lane_0_rdata2, lane_0_imm};
  assign in_pay[1] = {lane_1_pc, lane_1_rdata1, lane_1_rdata2, lane_1_imm};

  assign issue_ready = !full;
  assign pair_valid = full || issue_valid;

  assign pair0.ctrl = full ? held_ctrl[0] : in_ctrl[0];
  assign pair1.ctrl = full ? held_ctrl[1] : in_ctrl[1];
  assign {pair0.pc, pair0.rdata1, pair0.rdata2, pair0.imm} = full ? held_pay[0] : in_pay[0];
  assign {pair1.pc, pair1.rdata1, pair1.rdata2, pair1.imm} = full ? held_pay[1] : in_pay[1];

  // results are produced downstream.
  assign pair0.result = '0;
  assign pair0.jump = 1'b0;
  assign pair0.target = '0;
  assign pair0.ecause = cause_none;
  assign pair1.result = '0;
  assign pair1.jump = 1'b0;
  assign pair1.target = '0;
  assign pair1.ecause = cause_none;

  always_ff @(posedge clock) begin
    if (!reset || flush) begin
      full <= 1'b0;
    end else if (full && !stage_stall) begin
      full <= 1'b0; // entry drains into stage.
    end else if (!full && issue_valid && stage_stall) begin
      full <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (!full && issue_valid && stage_stall) begin
      held_ctrl <= in_ctrl;
      held_pay <= in_pay;
    end
  end

endmodule

// ==== verilog/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage #(
  parameter int data_width = 32
) (
  input logic clock,
  input logic reset,
  input logic flush,
  exec_lane_if.dst pair0,
  exec_lane_if.dst pair1,
  input logic pair_valid,
  output logic stage_stall,
  output exec_pkg::exec_op_t alu0_op,
  output logic alu0_use_imm,
  output logic [data_width-1:0] alu0_pc,
  output logic [data_width-1:0] alu0_rdata1,
  output logic [data_width-1:0] alu0_rdata2,
  output logic [data_width-1:0] alu0_imm,
  input logic [data_width-1:0] alu0_result,
  input logic alu0_jump,
  input logic [data_width-1:0] alu0_target,
  output exec_pkg::exec_op_t alu1_op,
  output logic alu1_use_imm,
  output logic [data_width-1:0] alu1_pc,
  output logic [data_width-1:0] alu1_rdata1,
  output logic [data_width-1:0] alu1_rdata2,
  output logic [data_width-1:0] alu1_imm,
  input logic [data_width-1:0] alu1_result,
  input logic alu1_jump,
  input logic [data_width-1:0] alu1_target,
  output logic div_start,
  output logic div_signed_op,
  output logic div_want_rem,
  output logic [data_width-1:0] div_dividend,
  output logic [data_width-1:0] div_divisor,
  input logic div_busy,
  input logic div_done,
  input logic [data_width-1:0] div_result,
  exec_lane_if.src out0,
  exec_lane_if.src out1
);
  import exec_pkg::*;

  lane_ctrl_t ctrl [2];
  logic [data_width-1:0] pc [2];
  logic [data_width-1:0] rs1 [2];
  logic [data_width-1:0] rs2 [2];
  logic [data_width-1:0] imm [2];
  logic div_started;
  logic fault0, fault1;
  logic div0, div1, pair_div, use_div1, div_need;
  logic jump0, squash1;
  exec_op_t div_op;

  always_ff @(posedge clock) begin
    if (!reset || flush) begin
      ctrl[0] <= '0;
      ctrl[1] <= '0;
    end else if (!stage_stall) begin
      ctrl[0] <= pair_valid ? pair0.ctrl : '0;
      ctrl[1] <= pair_valid ? pair1.ctrl : '0;
    end
  end

  always_ff @(posedge clock) begin
    if (!stage_stall) begin
      pc[0] <= pair0.pc;
      rs1[0] <= pair0.rdata1;
      rs2[0] <= pair0.rdata2;
      imm[0] <= pair0.imm;
      pc[1] <= pair1.pc;
      rs1[1] <= pair1.rdata1;
      rs2[1] <= pair1.rdata2;
      imm[1] <= pair1.imm;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset || flush || div_done) begin
      div_started <= 1'b0;
    end else if (div_start) begin
      div_started <= 1'b1;
    end
  end

  assign fault0 = ctrl[0].valid && (ctrl[0].op == op_illegal || ctrl[0].ebreak);
  assign fault1 = ctrl[1].valid && (ctrl[1].op == op_illegal || ctrl[1].ebreak);
  assign div0 = ctrl[0].valid && is_divide(ctrl[0].op) && !ctrl[0].ebreak;
  assign div1 = ctrl[1].valid && is_divide(ctrl[1].op) && !ctrl[1].ebreak;
  assign pair_div = div0 && div1; // one divider only.
  assign jump0 = ctrl[0].valid && !fault0 && alu0_jump;
  assign squash1 = fault0 || jump0;
  assign use_div1 = div1 && !div0 && !squash1;
  assign div_need = div0 || use_div1;
  assign stage_stall = div_need && !div_done;

  assign div_op = div0 ? ctrl[0].op : ctrl[1].op;
  assign div_start = div_need && !div_started && !div_busy;
  assign div_signed_op = div_op inside {op_div, op_rem};
  assign div_want_rem = div_op inside {op_rem, op_remu};
  assign div_dividend = div0 ? rs1[0] : rs1[1];
  assign div_divisor = div0 ? rs2[0] : rs2[1];

  assign alu0_op = ctrl[0].op;
  assign alu0_use_imm = ctrl[0].use_imm;
  assign {alu0_pc, alu0_rdata1, alu0_rdata2, alu0_imm} = {pc[0], rs1[0], rs2[0], imm[0]};
  assign alu1_op = ctrl[1].op;
  assign alu1_use_imm = ctrl[1].use_imm;
  assign {alu1_pc, alu1_rdata1, alu1_rdata2, alu1_imm} = {pc[1], rs1[1], rs2[1], imm[1]};

  always_comb begin
    out0.ctrl = ctrl[0];
    out0.ctrl.valid = ctrl[0].valid && !stage_stall;
    out1.ctrl = ctrl[1];
    out1.ctrl.valid = ctrl[1].valid && !stage_stall && !squash1;
  end

  assign {out0.pc, out0.rdata1, out0.rdata2, out0.imm} = {pc[0], rs1[0], rs2[0], imm[0]};
  assign {out1.pc, out1.rdata1, out1.rdata2, out1.imm} = {pc[1], rs1[1], rs2[1], imm[1]};
  assign out0.result = div0 ? div_result : alu0_result;
  assign out1.result = use_div1 ? div_result : alu1_result;
  assign out0.jump = jump0;
  assign out1.jump = ctrl[1].valid && !fault1 && alu1_jump;
  assign out0.target = alu0_target;
  assign out1.target = alu1_target;

  // illegal before breakpoint.
  assign out0.ecause = ctrl[0].op == op_illegal ? cause_illegal_instruction :
                       ctrl[0].ebreak ? cause_breakpoint : cause_none;
  assign out1.ecause = (ctrl[1].op == op_illegal || pair_div) ? cause_illegal_instruction :
                       ctrl[1].ebreak ? cause_breakpoint : cause_none;

endmodule

// ==== verilog/retire_register.sv ====
`timescale 1ns/1ps

module retire_register #(
  parameter int data_width = 32
) (
  input logic clock,
  input logic reset,
  input logic flush,
  exec_lane_if.dst out0,
  exec_lane_if.dst out1,
  output logic retire_0_valid,
  output logic [4:0] retire_0_waddr,
  output logic retire_0_wren,
  output logic [data_width-1:0] retire_0_result,
  output logic retire_0_exception,
  output exec_pkg::ecause_t retire_0_ecause,
  output logic retire_1_valid,
  output logic [4:0] retire_1_waddr,
  output logic retire_1_wren,
  output logic [data_width-1:0] retire_1_result,
  output logic retire_1_exception,
  output exec_pkg::ecause_t retire_1_ecause,
  output logic redirect_valid,
  output logic [data_width-1:0] redirect_pc
);
  import exec_pkg::*;

  function automatic logic writes(input lane_ctrl_t c, input ecause_t e);
    return c.valid && e == cause_none && !(c.op inside {op_nop, op_beq, op_bne, op_blt, op_bge});
  endfunction

  always_ff @(posedge clock) begin
    if (!reset || flush) begin
      retire_0_valid <= 1'b0;
      retire_1_valid <= 1'b0;
      redirect_valid <= 1'b0;
    end else begin
      retire_0_valid <= out0.ctrl.valid;
      retire_1_valid <= out1.ctrl.valid;
      redirect_valid <= (out0.ctrl.valid && out0.jump) || (out1.ctrl.valid && out1.jump);
    end
  end

  always_ff @(posedge clock) begin
    retire_0_waddr <= out0.ctrl.waddr;
    retire_0_wren <= writes(out0.ctrl, out0.ecause);
    retire_0_result <= out0.result;
    retire_0_exception <= out0.ecause != cause_none;
    retire_0_ecause <= out0.ecause;
    retire_1_waddr <= out1.ctrl.waddr;
    retire_1_wren <= writes(out1.ctrl, out1.ecause);
    retire_1_result <= out1.result;
    retire_1_exception <= out1.ecause != cause_none;
    retire_1_ecause <= out1.ecause;
    redirect_pc <= out0.jump ? out0.target : out1.target; // lane 0 wins.
  end

endmodule

// ==== verilog/dual_execute_top.sv ====
`timescale 1ns/1ps

module dual_execute_top #(
  parameter int data_width = 32
) (
  input logic clock,
  input logic reset,
  input logic flush,
  input logic issue_valid,
  output logic issue_ready,
  input exec_pkg::exec_op_t lane_0_op,
  input logic lane_0_use_imm,
  input logic [4:0] lane_0_waddr,
  input logic lane_0_ebreak,
  input logic [data_width-1:0] lane_0_pc,
  input logic [data_width-1:0] lane_0_rdata1,
  input logic [data_width-1:0] lane_0_rdata2,
  input logic [data_width-1:0] lane_0_imm,
  input exec_pkg::exec_op_t lane_1_op,
  input logic lane_1_use_imm,
  input logic [4:0] lane_1_waddr,
  input logic lane_1_ebreak,
  input logic [data_width-1:0] lane_1_pc,
  input logic [data_width-1:0] lane_1_rdata1,
  input logic [data_width-1:0] lane_1_rdata2,
  input logic [data_width-1:0] lane_1_imm,
  output logic retire_0_valid,
  output logic [4:0] retire_0_waddr,
  output logic retire_0_wren,
  output logic [data_width-1:0] retire_0_result,
  output logic retire_0_exception,
  output exec_pkg::ecause_t retire_0_ecause,
  output logic retire_1_valid,
  output logic [4:0] retire_1_waddr,
  output logic retire_1_wren,
  output logic [data_width-1:0] retire_1_result,
  output logic retire_1_exception,
  output exec_pkg::ecause_t retire_1_ecause,
  output logic redirect_valid,
  output logic [data_width-1:0] redirect_pc
);
  import exec_pkg::*;

  exec_lane_if #(.data_width(data_width)) pair0 ();
  exec_lane_if #(.data_width(data_width)) pair1 ();
  exec_lane_if #(.data_width(data_width)) out0 ();
  exec_lane_if #(.data_width(data_width)) out1 ();

  logic pair_valid, stage_stall;
  exec_op_t alu0_op, alu1_op;
  logic alu0_use_imm, alu1_use_imm, alu0_jump, alu1_jump;
  logic [data_width-1:0] alu0_pc, alu0_rdata1, alu0_rdata2, alu0_imm;
  logic [data_width-1:0] alu1_pc, alu1_rdata1, alu1_rdata2, alu1_imm;
  logic [data_width-1:0] alu0_result, alu0_target, alu1_result, alu1_target;
  logic div_start, div_signed_op, div_want_rem, div_busy, div_done;
  logic [data_width-1:0] div_dividend, div_divisor, div_result;

  issue_buffer #(.data_width(data_width)) buffer (.*);

  execute_stage #(.data_width(data_width)) stage (.*);

  int_alu #(.data_width(data_width)) alu0 (
    .op(alu0_op), .use_imm(alu0_use_imm), .pc(alu0_pc), .rdata1(alu0_rdata1),
    .rdata2(alu0_rdata2), .imm(alu0_imm), .result(alu0_result), .jump(alu0_jump),
    .target(alu0_target)
  );

  int_alu #(.data_width(data_width)) alu1 (
    .op(alu1_op), .use_imm(alu1_use_imm), .pc(alu1_pc), .rdata1(alu1_rdata1),
    .rdata2(alu1_rdata2), .imm(alu1_imm), .result(alu1_result), .jump(alu1_jump),
    .target(alu1_target)
  );

  serial_divider #(.data_width(data_width)) divider (
    .clock, .reset, .flush, .start(div_start), .signed_op(div_signed_op),
    .want_rem(div_want_rem), .dividend(div_dividend), .divisor(div_divisor),
    .busy(div_busy), .done(div_done), .result(div_result)
  );

  retire_register #(.data_width(data_width)) retire (.*);

endmodule

// ==== dv/tb_reference.svh ====
typedef struct packed {
  exec_op_t op;
  logic use_imm;
  logic [4:0] waddr;
  logic ebreak;
  logic [data_width-1:0] pc;
  logic [data_width-1:0] rdata1;
  logic [data_width-1:0] rdata2;
  logic [data_width-1:0] imm;
} lane_in_t;

typedef struct packed {
  logic valid;
  logic [4:0] waddr;
  logic wren;
  logic [data_width-1:0] result;
  ecause_t ecause;
} lane_exp_t;

typedef struct packed {
  lane_exp_t lane0;
  lane_exp_t lane1;
  logic redirect;
  logic [data_width-1:0] redirect_pc;
} pair_exp_t;

function automatic logic [data_width-1:0] alu_value(input lane_in_t l);
  logic [data_width-1:0] a;
  logic [data_width-1:0] b;
  int sh;
  a = l.rdata1;
  b = l.use_imm ? l.imm : l.rdata2;
  sh = int'(b % data_width); // only the low shift bits count.
  case (l.op)
    op_add: return a + b;
    op_sub: return a - b;
    op_and: return a & b;
    op_or: return a | b;
    op_xor: return a ^ b;
    op_sll: return a << sh;
    op_srl: return a >> sh;
    op_sra: return $signed(a) >>> sh;
    op_slt: return ($signed(a) < $signed(b)) ? data_width'(1) : '0;
    op_sltu: return (a < b) ? data_width'(1) : '0;
    op_lui: return l.imm;
    op_jal: return l.pc + data_width'(4);
    default: return '0;
  endcase
endfunction

function automatic logic branch_taken(input lane_in_t l);
  case (l.op)
    op_beq: return l.rdata1 == l.rdata2;
    op_bne: return l.rdata1 != l.rdata2;
    op_blt: return $signed(l.rdata1) < $signed(l.rdata2);
    op_bge: return $signed(l.rdata1) >= $signed(l.rdata2);
    op_jal: return 1'b1;
    default: return 1'b0;
  endcase
endfunction

// RISC-V rules for zero divisor and signed overflow.
function automatic logic [data_width-1:0] divide_value(input exec_op_t op,
                                                       input logic [data_width-1:0] a,
                                                       input logic [data_width-1:0] b);
  logic signed [data_width-1:0] sa;
  logic signed [data_width-1:0] sb;
  logic signed_op;
  logic want_rem;
  logic overflow;
  sa = a;
  sb = b;
  signed_op = op inside {op_div, op_rem};
  want_rem = op inside {op_rem, op_remu};
  overflow = signed_op && (a == {1'b1, {(data_width-1){1'b0}}}) && (b == '1);
  if (b == '0) begin
    return want_rem ? a : '1;
  end else if (overflow) begin
    return want_rem ? '0 : a;
  end else if (signed_op) begin
    if (want_rem) begin
      return sa % sb;
    end else begin
      return sa / sb;
    end
  end else if (want_rem) begin
    return a % b;
  end else begin
    return a / b;
  end
endfunction

function automatic lane_exp_t lane_expect(input lane_in_t l, input logic live,
                                          input logic force_illegal);
  lane_exp_t e;
  e.valid = live && l.op != op_nop;
  e.waddr = l.waddr;
  if (l.op == op_illegal || force_illegal) begin
    e.ecause = cause_illegal_instruction;
  end else if (l.ebreak) begin
    e.ecause = cause_breakpoint;
  end else begin
    e.ecause = cause_none;
  end
  e.wren = e.valid && e.ecause == cause_none &&
           !(l.op inside {op_nop, op_beq, op_bne, op_blt, op_bge});
  if (l.op inside {op_div, op_divu, op_rem, op_remu}) begin
    e.result = divide_value(l.op, l.rdata1, l.rdata2);
  end else begin
    e.result = alu_value(l);
  end
  return e;
endfunction

function automatic pair_exp_t expect_pair(input lane_in_t l0, input lane_in_t l1);
  pair_exp_t p;
  logic fault0;
  logic jump0;
  logic jump1;
  logic two_div;
  fault0 = l0.op != op_nop && (l0.op == op_illegal || l0.ebreak);
  jump0 = l0.op != op_nop && !fault0 && branch_taken(l0);
  two_div = l0.op inside {op_div, op_divu, op_rem, op_remu} && !l0.ebreak &&
            l1.op inside {op_div, op_divu, op_rem, op_remu} && !l1.ebreak;
  p.lane0 = lane_expect(l0, 1'b1, 1'b0);
  p.lane1 = lane_expect(l1, !(fault0 || jump0), two_div); // older lane wins.
  jump1 = p.lane1.valid && l1.op != op_illegal && !l1.ebreak && branch_taken(l1);
  p.redirect = jump0 || jump1;
  p.redirect_pc = jump0 ? l0.pc + l0.imm : l1.pc + l1.imm;
  return p;
endfunction

// ==== dv/tb_dual_execute.sv ====
`timescale 1ns/1ps

module tb_dual_execute;
  import exec_pkg::*;

  localparam int data_width = 32;
  localparam int n_alu = 40;
  localparam int n_branch = 20;
  localparam int n_div = 12;
  localparam int n_fault = 10;
  localparam int n_tail = 10;
  localparam int total_pairs = n_alu + n_branch + 2 * n_div + n_fault + 2 + n_tail;
  localparam int cycle_limit = total_pairs * (data_width + 8) + 100;

  `include "tb_reference.svh"

  logic clock = 1'b0;
  logic reset, flush, issue_valid, issue_ready;
  exec_op_t lane_0_op, lane_1_op;
  logic lane_0_use_imm, lane_0_ebreak, lane_1_use_imm, lane_1_ebreak;
  logic [4:0] lane_0_waddr, lane_1_waddr;
  logic [data_width-1:0] lane_0_pc, lane_0_rdata1, lane_0_rdata2, lane_0_imm;
  logic [data_width-1:0] lane_1_pc, lane_1_rdata1, lane_1_rdata2, lane_1_imm;
  logic retire_0_valid, retire_0_wren, retire_0_exception;
  logic retire_1_valid, retire_1_wren, retire_1_exception;
  logic [4:0] retire_0_waddr, retire_1_waddr;
  logic [data_width-1:0] retire_0_result, retire_1_result;
  ecause_t retire_0_ecause, retire_1_ecause;
  logic redirect_valid;
  logic [data_width-1:0] redirect_pc;

  pair_exp_t expected_q [$];
  pair_exp_t got;
  logic checking = 1'b0;
  int cycles = 0;

  dual_execute_top #(.data_width(data_width)) uut (.*);

  always #50 clock = ~clock;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic check_value(input string name, input logic [data_width-1:0] expected,
                             input logic [data_width-1:0] actual);
    if (expected !== actual) begin
      fail_run($sformatf("ERR %s expected 0x%h actual 0x%h", name, expected, actual));
    end
  endtask

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      fail_run("timeout, the DUT did not retire every pair in time");
    end
  end

  task automatic compare_lane(input int n, input lane_exp_t e, input logic valid,
                              input logic [4:0] waddr, input logic wren,
                              input logic [data_width-1:0] result, input logic exception,
                              input ecause_t ecause);
    string p;
    p = $sformatf("retire_%0d_", n);
    check_value({p, "valid"}, data_width'(e.valid), data_width'(valid));
    if (e.valid) begin
      check_value({p, "waddr"}, data_width'(e.waddr), data_width'(waddr));
      check_value({p, "wren"}, data_width'(e.wren), data_width'(wren));
      check_value({p, "exception"}, data_width'(e.ecause != cause_none),
                  data_width'(exception));
      check_value({p, "ecause"}, data_width'(e.ecause), data_width'(ecause));
      if (e.wren) begin
        check_value({p, "result"}, e.result, result);
      end
    end
  endtask

  // outputs are registered, so the falling edge sees them settled.
  always @(negedge clock) begin
    if (checking) begin
      if (retire_0_valid || retire_1_valid) begin
        if (expected_q.size() == 0) begin
          fail_run("a pair retired while none was outstanding");
        end else begin
          got = expected_q.pop_front();
          compare_lane(0, got.lane0, retire_0_valid, retire_0_waddr, retire_0_wren,
                       retire_0_result, retire_0_exception, retire_0_ecause);
          compare_lane(1, got.lane1, retire_1_valid, retire_1_waddr, retire_1_wren,
                       retire_1_result, retire_1_exception, retire_1_ecause);
          check_value("redirect_valid", data_width'(got.redirect), data_width'(redirect_valid));
          if (got.redirect) begin
            check_value("redirect_pc", got.redirect_pc, redirect_pc);
          end
        end
      end else begin
        check_value("redirect_valid", '0, data_width'(redirect_valid));
      end
    end
  end

  function automatic exec_op_t pick_op(input exec_op_t first, input int count);
    return exec_op_t'(int'(first) + int'($urandom_range(count - 1)));
  endfunction

  function automatic lane_in_t random_lane(input exec_op_t op);
    lane_in_t l;
    l.op = op;
    l.use_imm = 1'($urandom_range(1));
    l.waddr = 5'($urandom);
    l.ebreak = 1'b0;
    l.pc = data_width'($urandom) & ~data_width'(3);
    l.rdata1 = data_width'($urandom);
    l.rdata2 = data_width'($urandom);
    l.imm = data_width'($urandom);
    return l;
  endfunction

  // called at a rising edge, returns at the edge that accepts the pair.
  task automatic issue_pair(input lane_in_t l0, input lane_in_t l1);
    pair_exp_t e;
    e = expect_pair(l0, l1);
    lane_0_op <= l0.op;
    lane_0_use_imm <= l0.use_imm;
    lane_0_waddr <= l0.waddr;
    lane_0_ebreak <= l0.ebreak;
    lane_0_pc <= l0.pc;
    lane_0_rdata1 <= l0.rdata1;
    lane_0_rdata2 <= l0.rdata2;
    lane_0_imm <= l0.imm;
    lane_1_op <= l1.op;
    lane_1_use_imm <= l1.use_imm;
    lane_1_waddr <= l1.waddr;
    lane_1_ebreak <= l1.ebreak;
    lane_1_pc <= l1.pc;
    lane_1_rdata1 <= l1.rdata1;
    lane_1_rdata2 <= l1.rdata2;
    lane_1_imm <= l1.imm;
    issue_valid <= 1'b1;
    @(negedge clock);
    while (!issue_ready) @(negedge clock);
    if (e.lane0.valid || e.lane1.valid) begin
      expected_q.push_back(e);
    end
    @(posedge clock);
  endtask

  task automatic check_held_off();
    issue_valid <= 1'b0;
    @(negedge clock);
    check_value("issue_ready", '0, data_width'(issue_ready)); // buffer holds one pair.
    @(posedge clock);
  endtask

  task automatic alu_traffic(input int n);
    repeat (n) issue_pair(random_lane(pick_op(op_add, 11)), random_lane(pick_op(op_add, 11)));
  endtask

  task automatic branch_traffic(input int n);
    lane_in_t l0;
    lane_in_t l1;
    repeat (n) begin
      l0 = random_lane(pick_op(op_beq, 5));
      if ($urandom_range(1) == 0) begin
        l0.rdata2 = l0.rdata1;
      end
      l1 = random_lane(pick_op(op_add, 16)); // lane 1 may branch too.
      issue_pair(l0, l1);
    end
  endtask

  task automatic divide_traffic(input int n);
    lane_in_t l0;
    lane_in_t l1;
    int mode;
    repeat (n) begin
      mode = int'($urandom_range(2));
      l0 = random_lane(mode == 1 ? pick_op(op_add, 11) : pick_op(op_div, 4));
      l1 = random_lane(mode == 0 ? pick_op(op_add, 11) : pick_op(op_div, 4));
      case ($urandom_range(3))
        0: begin
          l0.rdata2 = '0;
          l1.rdata2 = '0;
        end
        1: begin
          l0.rdata1 = {1'b1, {(data_width-1){1'b0}}};
          l0.rdata2 = '1;
          l1.rdata1 = {1'b1, {(data_width-1){1'b0}}};
          l1.rdata2 = '1;
        end
        2: begin
          l0.rdata2 = data_width'($urandom_range(200)) - data_width'(100);
          l1.rdata2 = data_width'($urandom_range(200)) - data_width'(100);
        end
        default: ;
      endcase
      issue_pair(l0, l1);
      issue_pair(random_lane(pick_op(op_add, 11)), random_lane(pick_op(op_add, 11)));
      check_held_off();
    end
  endtask

  task automatic fault_traffic(input int n);
    lane_in_t l0;
    repeat (n) begin
      l0 = random_lane(pick_op(op_add, 11));
      if ($urandom_range(1) == 0) begin
        l0.op = op_illegal;
      end else begin
        l0.ebreak = 1'b1;
      end
      issue_pair(l0, random_lane(pick_op(op_add, 11)));
    end
  endtask

  task automatic flush_mid_divide();
    issue_pair(random_lane(op_div), random_lane(pick_op(op_add, 11)));
    issue_pair(random_lane(pick_op(op_add, 11)), random_lane(pick_op(op_add, 11)));
    issue_valid <= 1'b0;
    repeat (5) @(posedge clock);
    flush <= 1'b1;
    @(posedge clock);
    flush <= 1'b0;
    expected_q.delete(); // both pairs are dropped.
    @(negedge clock);
    check_value("issue_ready", data_width'(1), data_width'(issue_ready));
    @(posedge clock);
  endtask

  initial begin
    void'($urandom(19));
    reset = 1'b0;
    flush = 1'b0;
    issue_valid = 1'b0;
    lane_0_op = op_nop;
    lane_1_op = op_nop;
    {lane_0_use_imm, lane_0_waddr, lane_0_ebreak, lane_0_pc} = '0;
    {lane_0_rdata1, lane_0_rdata2, lane_0_imm} = '0;
    {lane_1_use_imm, lane_1_waddr, lane_1_ebreak, lane_1_pc} = '0;
    {lane_1_rdata1, lane_1_rdata2, lane_1_imm} = '0;
    repeat (3) @(posedge clock);
    reset <= 1'b1;
    checking = 1'b1;
    @(negedge clock);
    check_value("issue_ready", data_width'(1), data_width'(issue_ready));
    check_value("retire_0_valid", '0, data_width'(retire_0_valid));
    check_value("retire_1_valid", '0, data_width'(retire_1_valid));
    @(posedge clock);
    alu_traffic(n_alu);
    branch_traffic(n_branch);
    divide_traffic(n_div);
    fault_traffic(n_fault);
    flush_mid_divide();
    alu_traffic(n_tail);
    issue_valid <= 1'b0;
    while (expected_q.size() != 0) @(posedge clock);
    repeat (4) @(posedge clock);
    if (expected_q.size() != 0) begin
      fail_run("pairs still outstanding at the end of the run");
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

// ==== project.f ====
+incdir+dv
verilog/exec_pkg.sv
verilog/exec_lane_if.sv
verilog/int_alu.sv
verilog/serial_divider.sv
verilog/issue_buffer.sv
verilog/execute_stage.sv
verilog/retire_register.sv
verilog/dual_execute_top.sv
dv/tb_dual_execute.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it; the exit status is the simulator's.
cd "$(dirname "$0")" &&
  verilator --binary --timing --timescale 1ns/1ps -f project.f \
    --top-module tb_dual_execute -o sim_dual_execute &&
  ./obj_dir/sim_dual_execute || exit 1
